// ==== icache_top.f ====
design/icache_pkg.sv
design/icache_lookup.sv
design/icache_data.sv
design/icache_refill.sv
design/icache_top.sv
tb/icache_mem_model.sv
tb/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the icache testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module icache_tb -f icache_top.f -o icache_sim \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "SIMULATION PASSED" sim.log || exit 1

// ==== tb/icache_tb.sv ====
module icache_tb;

    localparam int WAIT_LIMIT = 200;

    logic Clk = 1'b0;
    logic reset;
    logic read_enable;
    logic busy;
    logic ready;
    logic mem_read_request;
    logic mem_data_ready;
    icache_pkg::addr_t read_address;
    icache_pkg::addr_t mem_read_address;
    icache_pkg::addr_t beat_address;
    icache_pkg::addr_t last_req_addr;
    icache_pkg::word_t instruction;
    icache_pkg::word_t mem_data_in;
    icache_pkg::addr_t pending [$];
    int                accept_cycles [$];
    integer seed;
    int errors = 0;
    int mismatches = 0;
    int accepted = 0;
    int responses = 0;
    int req_count = 0;
    int cycle = 0;
    logic req_prev = 1'b0;
    logic check_latency;

    icache_top u_dut (
        .Clk(Clk), .reset(reset), .read_enable(read_enable), .read_address(read_address),
        .instruction(instruction), .ready(ready), .busy(busy),
        .mem_read_address(mem_read_address), .mem_read_request(mem_read_request),
        .mem_data_in(mem_data_in), .mem_data_ready(mem_data_ready)
    );

    icache_mem_model u_mem (
        .Clk(Clk), .reset(reset), .mem_read_address(mem_read_address),
        .mem_read_request(mem_read_request), .mem_data_ready(mem_data_ready),
        .beat_address(beat_address)
    );

    always #10 Clk = ~Clk;

    // Fixed mix of the word address bits
    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t addr);
        icache_pkg::addr_t w;
        w = addr >> 2;
        return (w * 32'h9E37_79B1) ^ {w[15:0], w[31:16]} ^ 32'hC3A5_0F1E;
    endfunction

    function automatic icache_pkg::addr_t block_base(input icache_pkg::addr_t addr);
        return addr & ~icache_pkg::addr_t'((1 << icache_pkg::OFFSET_BITS) - 1);
    endfunction

    assign mem_data_in = expected_word(beat_address);

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge Clk) cycle <= cycle + 1;

    // Responses pop before the accept of the same cycle is pushed
    always @(negedge Clk) begin
        icache_pkg::addr_t addr;
        int                latency;
        if (!reset) begin
            if (ready && pending.size() == 0) begin
                errors++;
                $display("Error at %0t: ready with no fetch outstanding", $time);
            end else if (ready) begin
                addr    = pending.pop_front();
                latency = cycle - accept_cycles.pop_front();
                responses++;
                check_value("instruction", instruction, expected_word(addr));
                if (check_latency) check_value("ready latency", 32'(latency), 32'd1);
            end
            if (read_enable && !busy) begin
                pending.push_back(read_address);
                // Index of the coming edge that accepts this fetch
                accept_cycles.push_back(cycle + 1);
                accepted++;
            end
            if (mem_read_request && !req_prev) begin
                req_count++;
                last_req_addr = mem_read_address;
            end
            req_prev = mem_read_request;
        end
    end

    task automatic fetch(input icache_pkg::addr_t addr);
        int n;
        n = 0;
        read_enable  = 1'b1;
        read_address = addr;
        @(negedge Clk);
        while (busy && n < WAIT_LIMIT) begin
            n++;
            @(negedge Clk);
        end
        if (busy) begin
            errors++;
            $display("Error at %0t: fetch of %h never accepted, busy stuck", $time, addr);
        end
        @(posedge Clk);
        #1;
        read_enable = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge Clk);
        while ((pending.size() != 0 || busy || mem_read_request) && n < WAIT_LIMIT) begin
            n++;
            @(negedge Clk);
        end
        if (n == WAIT_LIMIT) begin
            errors++;
            $display("Error at %0t: cache did not go idle, responses missing", $time);
        end
        @(posedge Clk);
        #1;
    endtask

    task automatic fetch_counted(input icache_pkg::addr_t addr, input int exp_requests);
        int start;
        start = req_count;
        fetch(addr);
        wait_idle();
        check_value("memory request count", 32'(req_count - start), 32'(exp_requests));
        if (exp_requests != 0) check_value("mem_read_address", last_req_addr, block_base(addr));
    endtask

    initial begin
        int                start;
        int                gap;
        icache_pkg::addr_t addr;
        seed          = 32'h512b04ee;
        reset         = 1'b1;
        read_enable   = 1'b0;
        read_address  = '0;
        check_latency = 1'b0;
        repeat (10) @(posedge Clk);
        #1;
        reset = 1'b0;

        // Cold misses at a middle and a low word offset
        fetch_counted(32'h0000_1008, 1);
        fetch_counted(32'h0000_2004, 1);

        // Back-to-back hits in a filled block
        start         = req_count;
        check_latency = 1'b1;
        for (int i = 0; i < icache_pkg::BLOCK_WORDS; i++) begin
            fetch(32'h0000_1000 + icache_pkg::addr_t'(i * 4));
        end
        wait_idle();
        check_latency = 1'b0;
        check_value("memory request count", 32'(req_count - start), 32'd0);

        // Four blocks in set 3, then a fifth that evicts the first
        for (int i = 0; i < icache_pkg::NUM_WAYS; i++) begin
            fetch_counted(32'h0000_4030 + icache_pkg::addr_t'(i * 128), 1);
        end
        for (int i = 0; i < icache_pkg::NUM_WAYS; i++) begin
            fetch_counted(32'h0000_4034 + icache_pkg::addr_t'(i * 128), 0);
        end
        fetch_counted(32'h0000_4230, 1);
        fetch_counted(32'h0000_4238, 0);
        fetch_counted(32'h0000_403C, 1);

        // Random mix over 64 blocks
        for (int i = 0; i < 300; i++) begin
            addr = 32'h0000_8000 + (icache_pkg::addr_t'($random(seed)) & 32'h0000_03FC);
            fetch(addr);
            gap = $random(seed) & 3;
            if (gap > 0) begin
                repeat (gap) @(posedge Clk);
                #1;
            end
        end
        wait_idle();
        check_value("response count", 32'(responses), 32'(accepted));

        $display("Done: %0d errors, %0d mismatches, %0d fetches, %0d responses",
                 errors, mismatches, accepted, responses);
        if (errors == 0 && mismatches == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/icache_mem_model.sv ====
module icache_mem_model (
    input  logic              Clk,
    input  logic              reset,
    input  icache_pkg::addr_t mem_read_address,
    input  logic              mem_read_request,
    output logic              mem_data_ready,
    output icache_pkg::addr_t beat_address
);

    integer            seed;
    integer            gap;
    integer            beat;
    logic              active;
    icache_pkg::addr_t base;

    initial begin
        seed           = 32'h512b04ee;
        mem_data_ready = 1'b0;
        beat_address   = '0;
        active         = 1'b0;
        base           = '0;
        beat           = 0;
        gap            = 0;
    end

    // One beat per cycle at most, 0 to 3 idle cycles before each
    always begin
        @(posedge Clk);
        #1;
        if (reset) begin
            active         = 1'b0;
            mem_data_ready = 1'b0;
        end else if (!active) begin
            mem_data_ready = 1'b0;
            if (mem_read_request) begin
                active = 1'b1;
                base   = mem_read_address;
                beat   = 0;
                gap    = $random(seed) & 3;
            end
        end else if (beat == icache_pkg::BLOCK_WORDS) begin
            mem_data_ready = 1'b0;
            active         = 1'b0;
        end else if (gap > 0) begin
            mem_data_ready = 1'b0;
            gap            = gap - 1;
        end else begin
            mem_data_ready = 1'b1;
            beat_address   = base + icache_pkg::addr_t'(beat * (icache_pkg::WORD_BITS / 8));
            beat           = beat + 1;
            gap            = $random(seed) & 3;
        end
    end

endmodule

// ==== design/icache_top.sv ====
module icache_top (
    input  logic               Clk,
    input  logic               reset,
    input  logic               read_enable,
    input  icache_pkg::addr_t  read_address,
    output icache_pkg::word_t  instruction,
    output logic               ready,
    output logic               busy,
    output icache_pkg::addr_t  mem_read_address,
    output logic               mem_read_request,
    input  icache_pkg::word_t  mem_data_in,
    input  logic               mem_data_ready
);

    icache_pkg::lookup_result_t lookup_result;
    icache_pkg::lookup_result_t replay;
    icache_pkg::fill_t          fill;
    logic                       refill_done;

    icache_lookup u_lookup (
        .Clk          (Clk),
        .reset        (reset),
        .read_enable  (read_enable),
        .read_address (read_address),
        .fill         (fill),
        .refill_done  (refill_done),
        .busy         (busy),
        .result       (lookup_result)
    );

    icache_data u_data (
        .Clk         (Clk),
        .reset       (reset),
        .result      (lookup_result),
        .replay      (replay),
        .fill        (fill),
        .instruction (instruction),
        .ready       (ready)
    );

    icache_refill u_refill (
        .Clk              (Clk),
        .reset            (reset),
        .result           (lookup_result),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready),
        .fill             (fill),
        .replay           (replay),
        .refill_done      (refill_done)
    );

endmodule

// ==== design/icache_refill.sv ====
module icache_refill (
    input  logic                       Clk,
    input  logic                       reset,
    input  icache_pkg::lookup_result_t result,
    output icache_pkg::addr_t          mem_read_address,
    output logic                       mem_read_request,
    input  icache_pkg::word_t          mem_data_in,
    input  logic                       mem_data_ready,
    output icache_pkg::fill_t          fill,
    output icache_pkg::lookup_result_t replay,
    output logic                       refill_done
);

    icache_pkg::refill_state_t  state;
    icache_pkg::lookup_result_t miss_q;
    icache_pkg::block_t         buffer;
    icache_pkg::word_off_t      beat_cnt;

    logic start;
    logic collecting;
    logic beat;
    logic last_beat;

    assign start      = (state == icache_pkg::IDLE) && result.valid && !result.hit;
    assign collecting = (state == icache_pkg::REQUEST) || (state == icache_pkg::COLLECT);
    assign beat       = collecting && mem_data_ready;
    assign last_beat  = beat && (beat_cnt == icache_pkg::LAST_WORD);

    always_ff @(posedge Clk) begin
        if (reset) begin
            state            <= icache_pkg::IDLE;
            mem_read_request <= 1'b0;
            beat_cnt         <= '0;
        end else begin
            case (state)
                icache_pkg::IDLE: begin
                    if (start) begin
                        state            <= icache_pkg::REQUEST;
                        mem_read_request <= 1'b1;
                        beat_cnt         <= '0;
                    end
                end
                icache_pkg::REQUEST, icache_pkg::COLLECT: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + icache_pkg::word_off_t'(1);
                        if (last_beat) begin
                            state            <= icache_pkg::REPLAY;
                            mem_read_request <= 1'b0;
                        end else begin
                            state <= icache_pkg::COLLECT;
                        end
                    end
                end
                icache_pkg::REPLAY: begin
                    state <= icache_pkg::IDLE;
                end
                default: state <= icache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            miss_q           <= result;
            mem_read_address <= {result.addr[icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS],
                                 {icache_pkg::OFFSET_BITS{1'b0}}};
        end
        if (beat) begin
            buffer[beat_cnt] <= mem_data_in;
        end
    end

    // Last word goes straight from the bus into the arrays
    always_comb begin
        fill.valid  = last_beat;
        fill.set    = miss_q.set;
        fill.way    = miss_q.way;
        fill.tag    = icache_pkg::addr_tag(miss_q.addr);
        fill.block  = buffer;
        fill.block[icache_pkg::LAST_WORD] = mem_data_in;
    end

    always_comb begin
        replay       = miss_q;
        replay.valid = (state == icache_pkg::REPLAY);
        replay.hit   = 1'b1;
    end

    assign refill_done = (state == icache_pkg::REPLAY);

    a_addr_stable: assert property (@(posedge Clk) disable iff (reset)
        mem_read_request |=> !mem_read_request || $stable(mem_read_address))
        else $error("memory request address changed during refill");

endmodule

// ==== design/icache_data.sv ====
module icache_data (
    input  logic                       Clk,
    input  logic                       reset,
    input  icache_pkg::lookup_result_t result,
    input  icache_pkg::lookup_result_t replay,
    input  icache_pkg::fill_t          fill,
    output icache_pkg::word_t          instruction,
    output logic                       ready
);

    icache_pkg::block_t blocks [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];

    icache_pkg::lookup_result_t sel;
    logic                       do_read;

    // Replay and hits never overlap, replay wins anyway
    assign sel     = replay.valid ? replay : result;
    assign do_read = sel.valid && sel.hit;

    always_ff @(posedge Clk) begin
        if (fill.valid) begin
            blocks[fill.set][fill.way] <= fill.block;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            ready <= 1'b0;
        end else begin
            ready <= do_read;
        end
    end

    always_ff @(posedge Clk) begin
        if (do_read) begin
            instruction <= blocks[sel.set][sel.way][sel.word_off];
        end
    end

    a_no_replay_clash: assert property (@(posedge Clk) disable iff (reset)
        !(result.valid && result.hit && replay.valid))
        else $error("hit result and replay in the same cycle");

endmodule

// ==== design/icache_lookup.sv ====
module icache_lookup (
    input  logic                       Clk,
    input  logic                       reset,
    input  logic                       read_enable,
    input  icache_pkg::addr_t          read_address,
    input  icache_pkg::fill_t          fill,
    input  logic                       refill_done,
    output logic                       busy,
    output icache_pkg::lookup_result_t result
);

    icache_pkg::tag_t                    tags [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
    logic [icache_pkg::NUM_WAYS-1:0]     valid_bits [icache_pkg::NUM_SETS];
    icache_pkg::way_t                    rr_ptr [icache_pkg::NUM_SETS];

    icache_pkg::tag_t      req_tag;
    icache_pkg::set_idx_t  req_set;
    icache_pkg::word_off_t req_word;
    logic                  accept;
    logic                  hit;
    icache_pkg::way_t      hit_way;
    icache_pkg::way_t      victim;

    assign req_tag  = icache_pkg::addr_tag(read_address);
    assign req_set  = icache_pkg::addr_set(read_address);
    assign req_word = icache_pkg::addr_word(read_address);
    assign accept   = read_enable && !busy;

    // Tag compare, and lowest invalid way else round-robin for the victim
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        victim  = rr_ptr[req_set];
        for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (valid_bits[req_set][w] && tags[req_set][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = icache_pkg::way_t'(w);
            end
            if (!valid_bits[req_set][w]) begin
                victim = icache_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            result.valid <= 1'b0;
            busy         <= 1'b0;
        end else begin
            result.valid <= accept;
            if (accept && !hit) begin
                busy <= 1'b1;
            end else if (refill_done) begin
                busy <= 1'b0;
            end
        end
        if (accept) begin
            result.hit      <= hit;
            result.set      <= req_set;
            result.way      <= hit ? hit_way : victim;
            result.word_off <= req_word;
            result.addr     <= read_address;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                valid_bits[s] <= '0;
                rr_ptr[s]     <= '0;
            end
        end else if (fill.valid) begin
            valid_bits[fill.set][fill.way] <= 1'b1;
            // Only a replaced valid way moves the pointer on
            if (valid_bits[fill.set][fill.way]) begin
                rr_ptr[fill.set] <= rr_ptr[fill.set] + icache_pkg::way_t'(1);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (fill.valid) begin
            tags[fill.set][fill.way] <= fill.tag;
        end
    end

    // Fetches stay blocked until the replay of the refill
    a_refill_blocks_fetch: assert property (@(posedge Clk) disable iff (reset)
        (fill.valid || refill_done) |-> busy)
        else $error("refill in progress while fetches were not blocked");

endmodule

// ==== design/icache_pkg.sv ====
package icache_pkg;

    // Cache geometry
    localparam int ADDR_BITS     = 32;
    localparam int WORD_BITS     = 32;
    localparam int NUM_SETS      = 8;
    localparam int NUM_WAYS      = 4;
    localparam int BLOCK_WORDS   = 4;
    localparam int OFFSET_BITS   = 4;
    localparam int SET_BITS      = $clog2(NUM_SETS);
    localparam int WAY_BITS      = $clog2(NUM_WAYS);
    localparam int WORD_OFF_BITS = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS      = ADDR_BITS - SET_BITS - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0]     addr_t;
    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [SET_BITS-1:0]      set_idx_t;
    typedef logic [WAY_BITS-1:0]      way_t;
    typedef logic [WORD_OFF_BITS-1:0] word_off_t;
    typedef word_t [BLOCK_WORDS-1:0]  block_t;

    // Position of the final beat of a block
    localparam word_off_t LAST_WORD = word_off_t'(BLOCK_WORDS - 1);

    typedef struct packed {
        logic      valid;
        logic      hit;
        set_idx_t  set;
        way_t      way;
        word_off_t word_off;
        addr_t     addr;
    } lookup_result_t;

    typedef struct packed {
        logic     valid;
        set_idx_t set;
        way_t     way;
        tag_t     tag;
        block_t   block;
    } fill_t;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        COLLECT,
        REPLAY
    } refill_state_t;

    // Address fields
    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic set_idx_t addr_set(addr_t addr);
        return addr[OFFSET_BITS +: SET_BITS];
    endfunction

    function automatic word_off_t addr_word(addr_t addr);
        return addr[OFFSET_BITS-1 -: WORD_OFF_BITS];
    endfunction

endpackage
